/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= ctrl_tb
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output and log"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Done: errors found" $(LOG); then echo "simulation FAILED"; exit 1; fi
	@if ! grep -q "Done: no errors" $(LOG); then echo "simulation FAILED"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* compile.f */
verilog/ctrl_pkg.sv
verilog/exc_detect.sv
verilog/irq_arbiter.sv
verilog/ctrl_fsm.sv
verilog/ctrl_top.sv
sim/ctrl_checker.sv
sim/ctrl_tb.sv

/* sim/ctrl_checker.sv */
module ctrl_checker (
	input logic                clk_i,
	input logic                rst_ni,
	input logic                stall_i,
	input logic                pc_set_o,
	input ctrl_pkg::pc_sel_e   pc_mux_o,
	input ctrl_pkg::csr_ctrl_t csr_ctrl_o,
	input logic                id_in_ready_o
);
	timeunit 1ns;
	timeprecision 1ps;
	import ctrl_pkg::*;

	a_exc_saves_cause: assert property (@(posedge clk_i) disable iff (!rst_ni)
		(pc_set_o && pc_mux_o == PC_EXC) |-> csr_ctrl_o.save_cause)
		else $error("trap pc set without save_cause");

	a_stall_blocks_id: assert property (@(posedge clk_i) disable iff (!rst_ni)
		stall_i |-> !id_in_ready_o)
		else $error("id_in_ready_o high during stall");

	a_quiet_after_reset: assert property (@(posedge clk_i)
		$rose(rst_ni) |-> !(csr_ctrl_o.save_if | csr_ctrl_o.save_id |
			csr_ctrl_o.save_cause | csr_ctrl_o.restore_mret))
		else $error("csr strobe active right after reset");

endmodule

/* sim/ctrl_tb.sv */
module ctrl_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import ctrl_pkg::*;

	localparam int N_EXC = 40;
	localparam int N_IRQ = 30;
	localparam int NUM_TESTS = N_EXC + N_IRQ + 21;
	localparam int K_EXC = 0;
	localparam int K_IRQ = 1;
	localparam int K_ERET = 2;
	localparam int K_NONE = 3;
	localparam int K_JUMP = 4;
	localparam int K_BUSY = 5;
	localparam int K_REQ = 6;
	localparam int K_NMI = 7;
	localparam int K_READY = 8;

	typedef struct packed {
		decode_flags_t   flags;
		instr_info_t     info;
		priv_lvl_e       priv;
		logic            tw;
		logic            load_err;
		logic            store_err;
		logic [XLEN-1:0] addr;
	} stim_t;

	typedef struct {
		string           name;
		int              cyc;
		int              kind;
		exc_cause_t      cause;
		logic [XLEN-1:0] mtval;
		logic            bitv;
	} check_t;

	logic            clk_i;
	logic            rst_ni;
	logic            instr_valid;
	decode_flags_t   flags;
	instr_info_t     info;
	priv_lvl_e       priv;
	logic            tw;
	logic            mie;
	irq_vec_t        irqs;
	logic            load_err;
	logic            store_err;
	logic [XLEN-1:0] lsu_addr;
	logic            stall;
	logic            branch_set;
	logic            jump_set;
	logic            instr_req;
	logic            pc_set;
	pc_sel_e         pc_mux;
	exc_pc_sel_e     exc_pc_mux;
	csr_ctrl_t       csr_ctrl;
	logic            ctrl_busy;
	logic            id_in_ready;
	logic            instr_valid_clear;
	logic            flush_id;
	logic            nmi_mode;

	int     seed = 32'hae21_b1a9;
	int     errors = 0;
	int     tests_done = 0;
	int     neg_cnt = 0;
	check_t pending[$];

	ctrl_top #(.NumFastIrq(15)) UUT (
		.clk_i(clk_i), .rst_ni(rst_ni), .instr_valid_i(instr_valid), .flags_i(flags),
		.info_i(info), .priv_i(priv), .mstatus_tw_i(tw), .mstatus_mie_i(mie),
		.irqs_i(irqs), .load_err_i(load_err), .store_err_i(store_err),
		.lsu_addr_i(lsu_addr), .stall_i(stall), .branch_set_i(branch_set),
		.jump_set_i(jump_set), .instr_req_o(instr_req), .pc_set_o(pc_set),
		.pc_mux_o(pc_mux), .exc_pc_mux_o(exc_pc_mux), .csr_ctrl_o(csr_ctrl),
		.ctrl_busy_o(ctrl_busy), .id_in_ready_o(id_in_ready),
		.instr_valid_clear_o(instr_valid_clear), .flush_id_o(flush_id),
		.nmi_mode_o(nmi_mode)
	);

	bind ctrl_top ctrl_checker u_checker (
		.clk_i(clk_i), .rst_ni(rst_ni), .stall_i(stall_i), .pc_set_o(pc_set_o),
		.pc_mux_o(pc_mux_o), .csr_ctrl_o(csr_ctrl_o), .id_in_ready_o(id_in_ready_o)
	);

	initial begin
		clk_i = 1'b0;
		forever #4 clk_i = ~clk_i;
	end

	// expected trap outcome from the priority rules
	function automatic check_t ref_exc(stim_t s);
		check_t c;
		c.kind = K_EXC;
		c.mtval = '0;
		c.bitv = 1'b0;
		c.cause = '0;
		if (s.flags.fetch_err) begin
			c.cause = 6'd1;
			c.mtval = s.flags.fetch_err_plus2 ? s.info.pc + 32'd2 : s.info.pc;
		end else if (s.flags.illegal || (s.priv != PRIV_LVL_M &&
				(s.flags.mret || (s.tw && s.flags.wfi)))) begin
			c.cause = 6'd2;
			c.mtval = s.flags.is_compressed ? {16'h0, s.info.instr_c} : s.info.instr;
		end else if (s.flags.ecall) begin
			c.cause = (s.priv == PRIV_LVL_M) ? 6'd11 : 6'd8;
		end else if (s.flags.ebrk) begin
			c.cause = 6'd3;
		end else if (s.store_err) begin
			c.cause = 6'd7;
			c.mtval = s.addr;
		end else if (s.load_err) begin
			c.cause = 6'd5;
			c.mtval = s.addr;
		end else begin
			c.kind = K_ERET;	// only mret reaches here in these tests
		end
		return c;
	endfunction

	function automatic check_t ref_irq(irq_vec_t v, logic en, logic masked);
		check_t c;
		logic   any;
		c.mtval = '0;
		c.bitv = 1'b0;
		any = v.software | v.timer | v.external | (|v.fast);
		c.kind = (!masked && (v.nm || (any && en))) ? K_IRQ : K_NONE;	// nmi mode blocks all
		if (v.nm) c.cause = 6'h3F;
		else if (|v.fast) begin
			for (int i = 0; i < 15; i++) begin
				if (v.fast[i]) c.cause = 6'h30 + 6'(i);
			end
		end else if (v.external) c.cause = 6'h2B;
		else if (v.software) c.cause = 6'h23;
		else c.cause = 6'h27;
		return c;
	endfunction

	task automatic check_cause(string name, exc_cause_t exp, exc_cause_t act);
		if (act !== exp) begin
			$display("FAILED %s cause: expected %h, actual %h", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_word(string name, logic [XLEN-1:0] exp, logic [XLEN-1:0] act);
		if (act !== exp) begin
			$display("FAILED %s mtval: expected %h, actual %h", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_pc_sel(string name, pc_sel_e exp, pc_sel_e act);
		if (act !== exp) begin
			$display("FAILED %s pc_mux: expected %s, actual %s", name, exp.name(), act.name());
			errors++;
		end
	endtask

	task automatic check_bit(string name, logic exp, logic act);
		if (act !== exp) begin
			$display("FAILED %s: expected %b, actual %b", name, exp, act);
			errors++;
		end
	endtask

	task automatic expect_at(string name, int cyc, check_t c);
		c.name = name;
		c.cyc = cyc;
		pending.push_back(c);
	endtask

	task automatic expect_bit(string name, int cyc, int kind, logic v);
		check_t c;
		c.kind = kind;
		c.bitv = v;
		c.cause = '0;
		c.mtval = '0;
		expect_at(name, cyc, c);
	endtask

	always @(negedge clk_i) begin : compare
		check_t c;
		int     err_before;
		neg_cnt++;
		while (pending.size() != 0 && pending[0].cyc <= neg_cnt) begin
			c = pending.pop_front();
			err_before = errors;
			if (c.cyc != neg_cnt) begin
				$display("check %s was scheduled in the past", c.name);
				errors++;
			end
			case (c.kind)
				K_EXC: begin
					check_bit({c.name, " pc_set"}, 1'b1, pc_set);
					check_pc_sel(c.name, PC_EXC, pc_mux);
					check_bit({c.name, " exc_pc_mux"}, 1'b0, logic'(exc_pc_mux));
					check_bit({c.name, " save_id"}, 1'b1, csr_ctrl.save_id);
					check_bit({c.name, " flush_id"}, 1'b1, flush_id);
					check_bit({c.name, " instr_valid_clear"}, 1'b1, instr_valid_clear);
					check_cause(c.name, c.cause, csr_ctrl.cause);
					check_word(c.name, c.mtval, csr_ctrl.mtval);
				end
				K_IRQ: begin
					check_bit({c.name, " pc_set"}, 1'b1, pc_set);
					check_pc_sel(c.name, PC_EXC, pc_mux);
					check_bit({c.name, " exc_pc_mux"}, 1'b1, logic'(exc_pc_mux));
					check_bit({c.name, " save_if"}, 1'b1, csr_ctrl.save_if);
					check_cause(c.name, c.cause, csr_ctrl.cause);
				end
				K_ERET: begin
					check_bit({c.name, " pc_set"}, 1'b1, pc_set);
					check_pc_sel(c.name, PC_ERET, pc_mux);
					check_bit({c.name, " restore_mret"}, 1'b1, csr_ctrl.restore_mret);
					check_bit({c.name, " flush_id"}, 1'b1, flush_id);
					check_bit({c.name, " instr_valid_clear"}, 1'b1, instr_valid_clear);
				end
				K_NONE: begin
					check_bit({c.name, " pc_set"}, 1'b0, pc_set);
					check_bit({c.name, " save_cause"}, 1'b0, csr_ctrl.save_cause);
				end
				K_JUMP: begin
					check_bit({c.name, " pc_set"}, 1'b1, pc_set);
					check_pc_sel(c.name, PC_JUMP, pc_mux);
				end
				K_BUSY: check_bit({c.name, " ctrl_busy"}, c.bitv, ctrl_busy);
				K_REQ: check_bit({c.name, " instr_req"}, c.bitv, instr_req);
				K_READY: check_bit({c.name, " id_in_ready"}, c.bitv, id_in_ready);
				default: check_bit({c.name, " nmi_mode"}, c.bitv, nmi_mode);
			endcase
			tests_done++;
			$display("test %s: %s", c.name, (errors == err_before) ? "ok" : "mismatch");
		end
	end

	task automatic idle(int n);
		repeat (n) @(posedge clk_i);
	endtask

	task automatic run_exc(string name, stim_t s);
		@(posedge clk_i);
		instr_valid <= 1'b1;
		flags <= s.flags;
		info <= s.info;
		priv <= s.priv;
		tw <= s.tw;
		load_err <= s.load_err;
		store_err <= s.store_err;
		lsu_addr <= s.addr;
		expect_at(name, neg_cnt + 2, ref_exc(s));	// flush cycle
		@(posedge clk_i);
		instr_valid <= 1'b0;
		flags <= '0;
		load_err <= 1'b0;
		store_err <= 1'b0;
		idle(2);
	endtask

	task automatic run_irq(string name, irq_vec_t v, logic en, logic masked);
		@(posedge clk_i);
		irqs <= v;
		mie <= en;
		expect_at(name, neg_cnt + 2, ref_irq(v, en, masked));
		idle(2);
		irqs <= '0;
		mie <= 1'b0;
		idle(2);
	endtask

	task automatic rand_stim(output stim_t s);
		logic [31:0] r;
		r = $random(seed);
		s = '0;
		s.flags.fetch_err = (r[1:0] == 2'd0);
		s.flags.illegal = (r[3:2] == 2'd0);
		s.flags.ecall = (r[5:4] == 2'd0);
		s.flags.ebrk = (r[7:6] == 2'd0);
		s.store_err = (r[9:8] == 2'd0);
		s.load_err = (r[11:10] == 2'd0);
		s.flags.fetch_err_plus2 = r[12];
		s.flags.is_compressed = r[13];
		s.priv = r[14] ? PRIV_LVL_M : PRIV_LVL_U;
		s.tw = r[15];
		s.flags.csr_pipe_flush = r[16];
		if (!(s.flags.fetch_err | s.flags.illegal | s.flags.ecall | s.flags.ebrk |
				s.store_err | s.load_err)) begin
			s.flags.illegal = 1'b1;
		end
		s.info.instr = $random(seed);
		s.info.instr_c = 16'($random(seed));
		s.info.pc = $random(seed);
		s.addr = $random(seed);
	endtask

	function automatic stim_t sys_stim(priv_lvl_e p, logic t, logic ec, logic mr, logic wf);
		stim_t s;
		s = '0;
		s.priv = p;
		s.tw = t;
		s.flags.ecall = ec;
		s.flags.mret = mr;
		s.flags.wfi = wf;
		s.info.instr = 32'h3020_0073;
		s.info.pc = 32'h0000_1a40;
		return s;
	endfunction

	initial begin : watchdog
		repeat (NUM_TESTS * 40) @(posedge clk_i);
		$display("timeout: the run did not finish in time");
		$display("Done: errors found");
		$finish;
	end

	initial begin : stimulus
		stim_t    s;
		irq_vec_t v;
		logic     en;
		rst_ni = 1'b0;
		instr_valid = 1'b0;
		flags = '0;
		info = '0;
		priv = PRIV_LVL_M;
		tw = 1'b0;
		mie = 1'b0;
		irqs = '0;
		load_err = 1'b0;
		store_err = 1'b0;
		lsu_addr = '0;
		stall = 1'b0;
		branch_set = 1'b0;
		jump_set = 1'b0;
		repeat (10) @(posedge clk_i);
		rst_ni <= 1'b1;

		@(negedge clk_i);	// RESET
		check_bit("boot reset pc_set", 1'b1, pc_set);
		check_bit("boot reset instr_req", 1'b0, instr_req);
		check_pc_sel("boot reset", PC_BOOT, pc_mux);
		@(negedge clk_i);	// BOOT_SET
		check_bit("boot set pc_set", 1'b1, pc_set);
		check_bit("boot set instr_req", 1'b1, instr_req);
		check_pc_sel("boot set", PC_BOOT, pc_mux);
		@(negedge clk_i);	// FIRST_FETCH
		check_bit("first fetch pc_set", 1'b0, pc_set);
		check_bit("first fetch instr_req", 1'b1, instr_req);
		check_bit("first fetch id_in_ready", 1'b1, id_in_ready);
		$display("test boot: %s", (errors == 0) ? "ok" : "mismatch");
		tests_done++;
		idle(2);

		for (int i = 0; i < N_EXC; i++) begin
			rand_stim(s);
			run_exc($sformatf("exc_%0d", i), s);
		end

		run_exc("ecall_u", sys_stim(PRIV_LVL_U, 1'b0, 1'b1, 1'b0, 1'b0));
		run_exc("ecall_m", sys_stim(PRIV_LVL_M, 1'b0, 1'b1, 1'b0, 1'b0));
		run_exc("mret_u", sys_stim(PRIV_LVL_U, 1'b0, 1'b0, 1'b1, 1'b0));
		run_exc("wfi_tw_u", sys_stim(PRIV_LVL_U, 1'b1, 1'b0, 1'b0, 1'b1));
		run_exc("mret_m", sys_stim(PRIV_LVL_M, 1'b0, 1'b0, 1'b1, 1'b0));

		for (int i = 0; i < N_IRQ; i++) begin
			v = irq_vec_t'($random(seed));
			v.nm = 1'b0;
			if (v == '0) v.timer = 1'b1;
			en = 1'($random(seed));
			run_irq($sformatf("irq_%0d", i), v, en, 1'b0);
		end

		v = '0;
		v.nm = 1'b1;
		@(posedge clk_i);
		irqs <= v;
		expect_at("nmi_entry", neg_cnt + 2, ref_irq(v, 1'b0, 1'b0));
		idle(2);
		irqs <= '0;
		expect_bit("nmi_mode_set", neg_cnt + 1, K_NMI, 1'b1);
		v = '0;
		v.timer = 1'b1;
		run_irq("nmi_masks_timer", v, 1'b1, 1'b1);
		run_exc("nmi_mret", sys_stim(PRIV_LVL_M, 1'b0, 1'b0, 1'b1, 1'b0));
		expect_bit("nmi_mode_clear", neg_cnt + 1, K_NMI, 1'b0);
		idle(2);

		@(posedge clk_i);
		s = sys_stim(PRIV_LVL_M, 1'b0, 1'b0, 1'b0, 1'b1);
		instr_valid <= 1'b1;
		flags <= s.flags;
		priv <= PRIV_LVL_M;
		tw <= 1'b0;
		expect_bit("wait_sleep_busy", neg_cnt + 3, K_BUSY, 1'b0);
		expect_bit("sleep_busy", neg_cnt + 4, K_BUSY, 1'b0);
		expect_bit("sleep_req", neg_cnt + 4, K_REQ, 1'b0);
		@(posedge clk_i);
		instr_valid <= 1'b0;
		flags <= '0;
		idle(3);
		irqs.software <= 1'b1;	// wake without mie
		expect_bit("wake_busy", neg_cnt + 1, K_BUSY, 1'b1);
		expect_bit("wake_fetch_req", neg_cnt + 2, K_REQ, 1'b1);
		idle(2);
		irqs <= '0;
		idle(3);

		@(posedge clk_i);
		branch_set <= 1'b1;
		expect_bit("branch", neg_cnt + 1, K_JUMP, 1'b1);
		@(posedge clk_i);
		branch_set <= 1'b0;
		jump_set <= 1'b1;
		expect_bit("jump", neg_cnt + 1, K_JUMP, 1'b1);
		@(posedge clk_i);
		jump_set <= 1'b0;
		idle(2);

		v = '0;
		v.timer = 1'b1;
		@(posedge clk_i);
		stall <= 1'b1;
		irqs <= v;
		mie <= 1'b1;
		expect_bit("stall_defers_irq", neg_cnt + 2, K_NONE, 1'b0);
		expect_bit("stall_id_ready", neg_cnt + 2, K_READY, 1'b0);
		idle(3);
		stall <= 1'b0;
		expect_at("irq_after_stall", neg_cnt + 2, ref_irq(v, 1'b1, 1'b0));
		idle(2);
		irqs <= '0;
		mie <= 1'b0;
		idle(5);

		if (pending.size() != 0) begin
			$display("%0d checks were never reached", pending.size());
			errors++;
		end
		$display("summary: %0d tests, %0d errors", tests_done, errors);
		if (errors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

/* verilog/ctrl_fsm.sv */
module ctrl_fsm (
	input  logic                  clk_i,
	input  logic                  rst_ni,
	input  logic                  special_req_i,
	input  ctrl_pkg::exc_rec_t    exc_rec_i,
	input  logic                  handle_irq_i,
	input  logic                  wake_req_i,
	input  ctrl_pkg::exc_cause_t  irq_cause_i,
	input  logic                  stall_i,
	input  logic                  branch_set_i,
	input  logic                  jump_set_i,
	input  logic                  fetch_err_i,
	output logic                  in_flush_o,
	output logic                  irq_taken_o,
	output logic                  mret_taken_o,
	output logic                  instr_req_o,
	output logic                  pc_set_o,
	output ctrl_pkg::pc_sel_e     pc_mux_o,
	output ctrl_pkg::exc_pc_sel_e exc_pc_mux_o,
	output ctrl_pkg::csr_ctrl_t   csr_ctrl_o,
	output logic                  ctrl_busy_o,
	output logic                  id_in_ready_o,
	output logic                  instr_valid_clear_o,
	output logic                  flush_id_o
);
	import ctrl_pkg::*;

	ctrl_state_e state_q;
	ctrl_state_e state_d;
	logic        halt_if;
	logic        retain_id;
	logic        flush_id;

	always_comb begin
		state_d = state_q;
		instr_req_o = 1'b1;
		pc_set_o = 1'b0;
		pc_mux_o = PC_BOOT;
		exc_pc_mux_o = EXC_PC_IRQ;
		csr_ctrl_o = '0;
		ctrl_busy_o = 1'b1;
		irq_taken_o = 1'b0;
		mret_taken_o = 1'b0;
		halt_if = 1'b0;
		retain_id = 1'b0;
		flush_id = 1'b0;
		case (state_q)
			RESET: begin
				instr_req_o = 1'b0;
				pc_set_o = 1'b1;
				state_d = BOOT_SET;
			end
			BOOT_SET: begin
				pc_set_o = 1'b1;
				state_d = FIRST_FETCH;
			end
			WAIT_SLEEP: begin
				ctrl_busy_o = 1'b0;
				instr_req_o = 1'b0;
				halt_if = 1'b1;
				flush_id = 1'b1;
				state_d = SLEEP;
			end
			SLEEP: begin
				instr_req_o = 1'b0;
				halt_if = 1'b1;
				flush_id = 1'b1;
				if (wake_req_i) begin
					state_d = FIRST_FETCH;
				end else begin
					ctrl_busy_o = 1'b0;	// clock can be gated now
				end
			end
			FIRST_FETCH: begin
				if (handle_irq_i) begin
					halt_if = 1'b1;
					state_d = IRQ_TAKEN;
				end else if (!stall_i) begin
					state_d = DECODE;
				end
			end
			DECODE: begin
				pc_mux_o = PC_JUMP;
				if (special_req_i) begin
					retain_id = 1'b1;	// keep the instr until the flush resolves it
					state_d = FLUSH;
				end
				if ((branch_set_i || jump_set_i) && !fetch_err_i) begin
					pc_set_o = 1'b1;
				end
				if (handle_irq_i && stall_i) begin
					halt_if = 1'b1;	// irq waits for the stall to clear
				end
				if (handle_irq_i && !stall_i && !special_req_i) begin
					halt_if = 1'b1;
					state_d = IRQ_TAKEN;
				end
			end
			IRQ_TAKEN: begin
				pc_mux_o = PC_EXC;
				exc_pc_mux_o = EXC_PC_IRQ;
				if (handle_irq_i) begin
					pc_set_o = 1'b1;
					irq_taken_o = 1'b1;
					csr_ctrl_o.save_if = 1'b1;
					csr_ctrl_o.save_cause = 1'b1;
					csr_ctrl_o.cause = irq_cause_i;
				end
				state_d = DECODE;
			end
			FLUSH: begin
				halt_if = 1'b1;
				flush_id = 1'b1;
				state_d = DECODE;
				if (exc_rec_i.valid) begin
					pc_set_o = 1'b1;
					pc_mux_o = PC_EXC;
					exc_pc_mux_o = EXC_PC_EXC;
					csr_ctrl_o.save_id = 1'b1;
					csr_ctrl_o.save_cause = 1'b1;
					csr_ctrl_o.cause = exc_rec_i.cause;
					csr_ctrl_o.mtval = exc_rec_i.mtval;
				end else begin
					case (exc_rec_i.sys_op)
						SYS_MRET: begin
							pc_set_o = 1'b1;
							pc_mux_o = PC_ERET;
							mret_taken_o = 1'b1;
							csr_ctrl_o.restore_mret = 1'b1;
						end
						SYS_WFI: state_d = WAIT_SLEEP;
						SYS_CSR_FLUSH: begin
							if (handle_irq_i) begin
								state_d = IRQ_TAKEN;	// mie may just have been set
							end
						end
						default: ;
					endcase
				end
			end
			default: begin
				instr_req_o = 1'b0;
				state_d = RESET;
			end
		endcase
	end

	assign in_flush_o = (state_q == FLUSH);
	assign flush_id_o = flush_id;
	assign id_in_ready_o = ~stall_i & ~halt_if & ~retain_id;
	assign instr_valid_clear_o = ~(stall_i | retain_id) | flush_id;

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			state_q <= RESET;
		end else begin
			state_q <= state_d;
		end
	end

endmodule

/* verilog/ctrl_pkg.sv */
package ctrl_pkg;

	localparam int unsigned XLEN = 32;

	typedef enum logic [3:0] {
		RESET,
		BOOT_SET,
		WAIT_SLEEP,
		SLEEP,
		FIRST_FETCH,
		DECODE,
		IRQ_TAKEN,
		FLUSH
	} ctrl_state_e;

	typedef enum logic [2:0] {
		PC_BOOT,
		PC_JUMP,
		PC_EXC,
		PC_ERET
	} pc_sel_e;

	typedef enum logic [0:0] {
		EXC_PC_EXC,
		EXC_PC_IRQ
	} exc_pc_sel_e;

	typedef enum logic [1:0] {
		PRIV_LVL_U = 2'b00,
		PRIV_LVL_M = 2'b11
	} priv_lvl_e;

	// system ops that only flush, no trap
	typedef enum logic [1:0] {
		SYS_NONE,
		SYS_MRET,
		SYS_WFI,
		SYS_CSR_FLUSH
	} sys_op_e;

	typedef logic [5:0] exc_cause_t;	// msb set for interrupts

	localparam exc_cause_t EXC_CAUSE_INSTR_ACCESS_FAULT = 6'h01;
	localparam exc_cause_t EXC_CAUSE_ILLEGAL_INSN = 6'h02;
	localparam exc_cause_t EXC_CAUSE_BREAKPOINT = 6'h03;
	localparam exc_cause_t EXC_CAUSE_LOAD_ACCESS_FAULT = 6'h05;
	localparam exc_cause_t EXC_CAUSE_STORE_ACCESS_FAULT = 6'h07;
	localparam exc_cause_t EXC_CAUSE_ECALL_UMODE = 6'h08;
	localparam exc_cause_t EXC_CAUSE_ECALL_MMODE = 6'h0B;
	localparam exc_cause_t EXC_CAUSE_IRQ_SOFTWARE_M = 6'h23;
	localparam exc_cause_t EXC_CAUSE_IRQ_TIMER_M = 6'h27;
	localparam exc_cause_t EXC_CAUSE_IRQ_EXTERNAL_M = 6'h2B;
	localparam exc_cause_t EXC_CAUSE_IRQ_NM = 6'h3F;
	localparam exc_cause_t EXC_CAUSE_IRQ_FAST_BASE = 6'h30;

	typedef struct packed {
		logic illegal;
		logic ecall;
		logic mret;
		logic wfi;
		logic ebrk;
		logic csr_pipe_flush;
		logic fetch_err;
		logic fetch_err_plus2;	// fault sits in the upper half of the instr
		logic is_compressed;
	} decode_flags_t;

	typedef struct packed {
		logic [31:0] instr;
		logic [15:0] instr_c;
		logic [XLEN-1:0] pc;
	} instr_info_t;

	typedef struct packed {
		logic valid;
		sys_op_e sys_op;
		exc_cause_t cause;
		logic [XLEN-1:0] mtval;
	} exc_rec_t;

	typedef struct packed {
		logic nm;
		logic software;
		logic timer;
		logic external;
		logic [14:0] fast;
	} irq_vec_t;

	typedef struct packed {
		logic save_if;
		logic save_id;
		logic save_cause;
		logic restore_mret;
		exc_cause_t cause;
		logic [XLEN-1:0] mtval;
	} csr_ctrl_t;

endpackage

/* verilog/ctrl_top.sv */
module ctrl_top #(
	parameter int unsigned NumFastIrq = 15
) (
	input  logic                      clk_i,
	input  logic                      rst_ni,
	input  logic                      instr_valid_i,
	input  ctrl_pkg::decode_flags_t   flags_i,
	input  ctrl_pkg::instr_info_t     info_i,
	input  ctrl_pkg::priv_lvl_e       priv_i,
	input  logic                      mstatus_tw_i,
	input  logic                      mstatus_mie_i,
	input  ctrl_pkg::irq_vec_t        irqs_i,
	input  logic                      load_err_i,
	input  logic                      store_err_i,
	input  logic [ctrl_pkg::XLEN-1:0] lsu_addr_i,
	input  logic                      stall_i,
	input  logic                      branch_set_i,
	input  logic                      jump_set_i,
	output logic                      instr_req_o,
	output logic                      pc_set_o,
	output ctrl_pkg::pc_sel_e         pc_mux_o,
	output ctrl_pkg::exc_pc_sel_e     exc_pc_mux_o,
	output ctrl_pkg::csr_ctrl_t       csr_ctrl_o,
	output logic                      ctrl_busy_o,
	output logic                      id_in_ready_o,
	output logic                      instr_valid_clear_o,
	output logic                      flush_id_o,
	output logic                      nmi_mode_o
);
	import ctrl_pkg::*;

	logic       special_req;
	logic       fetch_err;
	exc_rec_t   exc_rec;
	logic       in_flush;
	logic       handle_irq;
	logic       wake_req;
	exc_cause_t irq_cause;
	logic       irq_taken;
	logic       mret_taken;

	exc_detect u_exc_detect (
		.clk_i         (clk_i),
		.rst_ni        (rst_ni),
		.instr_valid_i (instr_valid_i),
		.flags_i       (flags_i),
		.info_i        (info_i),
		.priv_i        (priv_i),
		.mstatus_tw_i  (mstatus_tw_i),
		.load_err_i    (load_err_i),
		.store_err_i   (store_err_i),
		.lsu_addr_i    (lsu_addr_i),
		.in_flush_i    (in_flush),
		.special_req_o (special_req),
		.fetch_err_o   (fetch_err),
		.exc_rec_o     (exc_rec)
	);

	irq_arbiter #(
		.NumFastIrq (NumFastIrq)
	) u_irq_arbiter (
		.clk_i         (clk_i),
		.rst_ni        (rst_ni),
		.irqs_i        (irqs_i),
		.mstatus_mie_i (mstatus_mie_i),
		.irq_taken_i   (irq_taken),
		.mret_taken_i  (mret_taken),
		.handle_irq_o  (handle_irq),
		.wake_req_o    (wake_req),
		.irq_cause_o   (irq_cause),
		.nmi_mode_o    (nmi_mode_o)
	);

	ctrl_fsm u_ctrl_fsm (
		.clk_i               (clk_i),
		.rst_ni              (rst_ni),
		.special_req_i       (special_req),
		.exc_rec_i           (exc_rec),
		.handle_irq_i        (handle_irq),
		.wake_req_i          (wake_req),
		.irq_cause_i         (irq_cause),
		.stall_i             (stall_i),
		.branch_set_i        (branch_set_i),
		.jump_set_i          (jump_set_i),
		.fetch_err_i         (fetch_err),
		.in_flush_o          (in_flush),
		.irq_taken_o         (irq_taken),
		.mret_taken_o        (mret_taken),
		.instr_req_o         (instr_req_o),
		.pc_set_o            (pc_set_o),
		.pc_mux_o            (pc_mux_o),
		.exc_pc_mux_o        (exc_pc_mux_o),
		.csr_ctrl_o          (csr_ctrl_o),
		.ctrl_busy_o         (ctrl_busy_o),
		.id_in_ready_o       (id_in_ready_o),
		.instr_valid_clear_o (instr_valid_clear_o),
		.flush_id_o          (flush_id_o)
	);

endmodule

/* verilog/exc_detect.sv */
module exc_detect (
	input  logic                          clk_i,
	input  logic                          rst_ni,
	input  logic                          instr_valid_i,
	input  ctrl_pkg::decode_flags_t       flags_i,
	input  ctrl_pkg::instr_info_t         info_i,
	input  ctrl_pkg::priv_lvl_e           priv_i,
	input  logic                          mstatus_tw_i,
	input  logic                          load_err_i,
	input  logic                          store_err_i,
	input  logic [ctrl_pkg::XLEN-1:0]     lsu_addr_i,
	input  logic                          in_flush_i,
	output logic                          special_req_o,
	output logic                          fetch_err_o,
	output ctrl_pkg::exc_rec_t            exc_rec_o
);
	import ctrl_pkg::*;

	decode_flags_t flags;
	logic          illegal_umode;
	logic          illegal;
	exc_rec_t      rec_d;

	assign flags = instr_valid_i ? flags_i : '0;
	assign illegal_umode = (priv_i != PRIV_LVL_M) & (flags.mret | (mstatus_tw_i & flags.wfi));
	assign illegal = flags.illegal | illegal_umode;

	// fixed priority, first match wins
	always_comb begin
		rec_d = '0;
		if (flags.fetch_err) begin
			rec_d.valid = 1'b1;
			rec_d.cause = EXC_CAUSE_INSTR_ACCESS_FAULT;
			rec_d.mtval = flags.fetch_err_plus2 ? info_i.pc + 32'd2 : info_i.pc;
		end else if (illegal) begin
			rec_d.valid = 1'b1;
			rec_d.cause = EXC_CAUSE_ILLEGAL_INSN;
			rec_d.mtval = flags.is_compressed ? {16'h0000, info_i.instr_c} : info_i.instr;
		end else if (flags.ecall) begin
			rec_d.valid = 1'b1;
			rec_d.cause = (priv_i == PRIV_LVL_M) ? EXC_CAUSE_ECALL_MMODE : EXC_CAUSE_ECALL_UMODE;
		end else if (flags.ebrk) begin
			rec_d.valid = 1'b1;
			rec_d.cause = EXC_CAUSE_BREAKPOINT;
		end else if (store_err_i) begin
			rec_d.valid = 1'b1;
			rec_d.cause = EXC_CAUSE_STORE_ACCESS_FAULT;
			rec_d.mtval = lsu_addr_i;
		end else if (load_err_i) begin
			rec_d.valid = 1'b1;
			rec_d.cause = EXC_CAUSE_LOAD_ACCESS_FAULT;
			rec_d.mtval = lsu_addr_i;
		end else if (flags.mret) begin
			rec_d.sys_op = SYS_MRET;
		end else if (flags.wfi) begin
			rec_d.sys_op = SYS_WFI;
		end else if (flags.csr_pipe_flush) begin
			rec_d.sys_op = SYS_CSR_FLUSH;
		end
		if (in_flush_i) begin
			rec_d = '0;	// the flushed instr must not trap twice
		end
	end

	assign special_req_o = rec_d.valid | (rec_d.sys_op != SYS_NONE);
	assign fetch_err_o = flags.fetch_err & ~in_flush_i;

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			exc_rec_o <= '0;
		end else begin
			exc_rec_o <= rec_d;
		end
	end

endmodule

/* verilog/irq_arbiter.sv */
module irq_arbiter #(
	parameter int unsigned NumFastIrq = 15
) (
	input  logic                 clk_i,
	input  logic                 rst_ni,
	input  ctrl_pkg::irq_vec_t   irqs_i,
	input  logic                 mstatus_mie_i,
	input  logic                 irq_taken_i,
	input  logic                 mret_taken_i,
	output logic                 handle_irq_o,
	output logic                 wake_req_o,
	output ctrl_pkg::exc_cause_t irq_cause_o,
	output logic                 nmi_mode_o
);
	import ctrl_pkg::*;

	logic [NumFastIrq-1:0] fast_act;
	logic [3:0]            fast_id;
	logic                  irq_pending;
	logic                  nmi_mode_q;

	assign fast_act = irqs_i.fast[NumFastIrq-1:0];
	assign irq_pending = irqs_i.software | irqs_i.timer | irqs_i.external | (|fast_act);

	assign handle_irq_o = ~nmi_mode_q & (irqs_i.nm | (irq_pending & mstatus_mie_i));
	assign wake_req_o = irqs_i.nm | irq_pending;	// wake ignores mie

	// highest index wins
	always_comb begin
		fast_id = 4'd0;
		for (int unsigned i = 0; i < NumFastIrq; i++) begin
			if (fast_act[i]) begin
				fast_id = 4'(i);
			end
		end
	end

	always_comb begin
		if (irqs_i.nm) begin
			irq_cause_o = EXC_CAUSE_IRQ_NM;
		end else if (|fast_act) begin
			irq_cause_o = EXC_CAUSE_IRQ_FAST_BASE + exc_cause_t'(fast_id);
		end else if (irqs_i.external) begin
			irq_cause_o = EXC_CAUSE_IRQ_EXTERNAL_M;
		end else if (irqs_i.software) begin
			irq_cause_o = EXC_CAUSE_IRQ_SOFTWARE_M;
		end else begin
			irq_cause_o = EXC_CAUSE_IRQ_TIMER_M;
		end
	end

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			nmi_mode_q <= 1'b0;
		end else if (irq_taken_i && irq_cause_o == EXC_CAUSE_IRQ_NM) begin
			nmi_mode_q <= 1'b1;
		end else if (mret_taken_i) begin
			nmi_mode_q <= 1'b0;
		end
	end

	assign nmi_mode_o = nmi_mode_q;

endmodule
